// ==== project.f ====
+incdir+include
verilog/vec_pkg.sv
verilog/vsetvl_unit.sv
verilog/vector_csr.sv
verilog/csr_access.sv
verilog/fixp_alu.sv
verilog/vec_csr_top.sv
tests/vec_csr_assert.sv
tests/tb_vec_csr_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_vec_csr_top
FILELIST  ?= project.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== tests/tb_vec_csr_top.sv ====
// ======================================================================
// Vector CSR subsystem testbench
// Reference model of vsetvl, CSR shadow and fixed-point ALU
// ======================================================================
`timescale 1ns/1ps
`include "vec_defs.svh"

module tb_vec_csr_top;
    import vec_pkg::*;

    localparam int N_VSET = 48;
    localparam int N_RND  = 16;
    localparam int N_SAT  = 24;
    // reset, reset reads, vsetvl, CSR section, rounding, saturation, drain
    localparam int STIM_CYCLES = 2 + 7 + N_VSET + 2 + 17 + 4 * (N_RND + 1) + 12 + N_SAT + 3;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic      clk;
    logic      rst;
    logic      vset_valid;
    vset_req_t vset_req;
    logic      csr_valid;
    csr_req_t  csr_req;
    logic      fixp_valid;
    fixp_req_t fixp_req;
    vl_t       vl_out;
    vtype_t    vtype_out;
    csr_word_u csr_rdata;
    logic      csr_err;
    logic      fixp_rsp_valid;
    fixp_rsp_t fixp_rsp;

    // Shadow copy of the CSR state
    vtype_t      sh_vtype;
    vl_t         sh_vl;
    vl_t         sh_vstart;
    vxrm_e       sh_vxrm;
    logic        sh_vxsat;
    logic        sat_pend;
    logic        err_pend;
    logic        err_exp;
    logic        valid_pend;
    logic        valid_exp;
    fixp_rsp_t   exp_fixp[$];
    fixp_rsp_t   exp_rsp;
    logic [31:0] rng = 32'hf5cd_b42a;
    int          cycle_cnt = 0;
    vtype_t      vt;
    logic [31:0] avl;
    logic [11:0] addr_list [0:6] = '{`VEC_CSR_VSTART, `VEC_CSR_VXSAT, `VEC_CSR_VXRM,
                                     `VEC_CSR_VCSR, `VEC_CSR_VL, `VEC_CSR_VTYPE,
                                     `VEC_CSR_VLENB};

    vec_csr_top UUT (
        .clk, .rst, .vset_valid, .vset_req, .csr_valid, .csr_req, .fixp_valid, .fixp_req,
        .vl_out, .vtype_out, .csr_rdata, .csr_err, .fixp_rsp_valid, .fixp_rsp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void ref_vsetvl(input logic [31:0] req_avl, input vtype_t req,
                                       output vtype_t new_vt, output vl_t new_vl);
        logic [31:0] vlmax;
        vlmax = `VEC_VLEN >> (3 + 32'(req.sew));
        if (3'(req.sew) > 3'd3 || 3'(req.vlmul) != 3'd0) begin
            new_vt      = '0;
            new_vt.vill = 1'b1;
            new_vl      = '0;
        end else begin
            new_vt      = req;
            new_vt.vill = 1'b0;
            new_vt.rsvd = '0;
            new_vl      = (req_avl < vlmax) ? vl_t'(req_avl) : vl_t'(vlmax);
        end
    endfunction

    function automatic fixp_rsp_t ref_fixp(input fixp_op_e op, input logic [7:0] a,
                                           input logic [7:0] b, input vxrm_e mode);
        int        s;
        int        q;
        int        d;
        fixp_rsp_t r;
        s     = int'($signed(a)) + int'($signed(b));
        q     = s >>> 1;
        d     = s & 1;
        r.sat = 1'b0;
        if (op == FIXP_AADD) begin
            case (mode)
                VXRM_RNU: q = q + d;
                VXRM_RNE: q = q + (d & q);
                VXRM_ROD: q = q | d;
                default: ;  // rdn keeps the truncated value
            endcase
            r.result = 8'(q);
        end else if (s > 127) begin
            r.result = 8'h7f;
            r.sat    = 1'b1;
        end else if (s < -128) begin
            r.result = 8'h80;
            r.sat    = 1'b1;
        end else begin
            r.result = 8'(s);
        end
        return r;
    endfunction

    function automatic csr_word_u ref_read(input logic [11:0] addr);
        csr_word_u w;
        w.raw = '0;
        case (addr)
            `VEC_CSR_VSTART: w.raw = 32'(sh_vstart);
            `VEC_CSR_VXSAT:  w.raw[0] = sh_vxsat;
            `VEC_CSR_VXRM:   w.raw[1:0] = sh_vxrm;
            `VEC_CSR_VCSR:   w.raw[2:0] = {sh_vxrm, sh_vxsat};
            `VEC_CSR_VL:     w.raw = 32'(sh_vl);
            `VEC_CSR_VTYPE:  w.raw = sh_vtype;
            `VEC_CSR_VLENB:  w.raw = `VEC_VLEN / 8;
            default:         w.raw = '0;
        endcase
        return w;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_vtype(input vtype_t got, input vtype_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: vtype_out = 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_vl(input vl_t got, input vl_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: vl_out = 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_word(input string name, input csr_word_u got, input csr_word_u exp);
        if (got.raw !== exp.raw) begin
            stop_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_fixp(input fixp_rsp_t got, input fixp_rsp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: fixp_rsp = 0x%h, expected 0x%h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Strobes drop at each new cycle unless driven again
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (sat_pend) begin
            sh_vxsat = 1'b1;
        end
        sat_pend   = 1'b0;
        err_pend   = 1'b0;
        valid_pend = 1'b0;
        vset_valid = 1'b0;
        csr_valid  = 1'b0;
        fixp_valid = 1'b0;
    endtask

    task automatic drive_csr(input logic [11:0] addr, input logic wr, input logic [31:0] data);
        csr_valid         = 1'b1;
        csr_req.addr      = addr;
        csr_req.write     = wr;
        csr_req.wdata.raw = data;
        if (wr) begin
            case (addr)
                `VEC_CSR_VSTART: sh_vstart = vl_t'(data);
                `VEC_CSR_VXSAT:  sh_vxsat = data[0];
                `VEC_CSR_VXRM:   sh_vxrm = vxrm_e'(data[1:0]);
                `VEC_CSR_VCSR: begin
                    sh_vxrm  = vxrm_e'(data[2:1]);
                    sh_vxsat = data[0];
                end
                default: err_pend = 1'b1;
            endcase
        end else begin
            err_pend = !(addr inside {`VEC_CSR_VSTART, `VEC_CSR_VXSAT, `VEC_CSR_VXRM,
                                      `VEC_CSR_VCSR, `VEC_CSR_VL, `VEC_CSR_VTYPE,
                                      `VEC_CSR_VLENB});
        end
    endtask

    task automatic request_vset(input logic [31:0] req_avl, input vtype_t req_vt);
        vset_valid     = 1'b1;
        vset_req.avl   = req_avl;
        vset_req.vtype = req_vt;
        ref_vsetvl(req_avl, req_vt, sh_vtype, sh_vl);
    endtask

    // Call after any vxrm write of the same cycle
    task automatic issue_fixp(input fixp_op_e op, input logic [7:0] a, input logic [7:0] b);
        fixp_rsp_t r;
        r           = ref_fixp(op, a, b, sh_vxrm);
        fixp_valid  = 1'b1;
        fixp_req.op = op;
        fixp_req.a  = a;
        fixp_req.b  = b;
        exp_fixp.push_back(r);
        sat_pend   = r.sat;
        valid_pend = 1'b1;
    endtask

    task automatic csr_cycle(input logic [11:0] addr, input logic wr, input logic [31:0] data);
        next_cycle();
        drive_csr(addr, wr, data);
        @(negedge clk);
        check_word("csr_rdata", csr_rdata, ref_read(addr));
    endtask

    task automatic vset_cycle(input logic [31:0] req_avl, input vtype_t req_vt,
                              input logic [11:0] rd_addr);
        next_cycle();
        request_vset(req_avl, req_vt);
        drive_csr(rd_addr, 1'b0, 32'd0);
        @(negedge clk);
        check_vl(vl_out, sh_vl);
        check_vtype(vtype_out, sh_vtype);
        check_word("csr_rdata", csr_rdata, ref_read(rd_addr));
    endtask

    task automatic fixp_cycle(input fixp_op_e op, input logic [7:0] a, input logic [7:0] b,
                              input logic [11:0] rd_addr);
        next_cycle();
        issue_fixp(op, a, b);
        drive_csr(rd_addr, 1'b0, 32'd0);
        @(negedge clk);
        check_word("csr_rdata", csr_rdata, ref_read(rd_addr));
    endtask

    // Compare process for the registered outputs
    always @(negedge clk) begin
        if (!rst) begin
            check_flag("csr_err", csr_err, err_exp);
            check_flag("fixp_rsp_valid", fixp_rsp_valid, valid_exp);
            err_exp   = err_pend;
            valid_exp = valid_pend;
            if (fixp_rsp_valid) begin
                exp_rsp = exp_fixp.pop_front();
                check_fixp(fixp_rsp, exp_rsp);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            stop_run($sformatf("Run exceeded the limit of %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst            = 1'b1;
        vset_valid     = 1'b0;
        vset_req       = '0;
        csr_valid      = 1'b0;
        csr_req        = '0;
        fixp_valid     = 1'b0;
        fixp_req       = '0;
        sh_vtype       = '0;
        sh_vtype.vill  = 1'b1;
        sh_vl          = '0;
        sh_vstart      = '0;
        sh_vxrm        = VXRM_RNU;
        sh_vxsat       = 1'b0;
        sat_pend       = 1'b0;
        err_pend       = 1'b0;
        err_exp        = 1'b0;
        valid_pend     = 1'b0;
        valid_exp      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 7; i++) begin
            csr_cycle(addr_list[i], 1'b0, 32'd0);
        end

        // Random vsetvl requests, about half the SEW codes reserved and some LMUL illegal
        for (int i = 0; i < N_VSET; i++) begin
            rng      = xorshift(rng);
            vt       = '0;
            vt.ta    = rng[12];
            vt.ma    = rng[13];
            vt.sew   = sew_e'(rng[3] ? rng[2:0] : {1'b0, rng[1:0]});
            vt.vlmul = (rng[7:4] == 4'd0) ? lmul_e'(rng[10:8]) : LMUL_1;
            avl      = rng[11] ? rng : 32'(rng[31:26]);
            vset_cycle(avl, vt, rng[14] ? `VEC_CSR_VL : `VEC_CSR_VTYPE);
        end
        vt       = '0;
        vt.vlmul = LMUL_2;
        vset_cycle(32'd9, vt, `VEC_CSR_VTYPE);
        vt.vlmul = LMUL_1;
        vt.sew   = sew_e'(3'b110);
        vset_cycle(32'd9, vt, `VEC_CSR_VL);

        csr_cycle(`VEC_CSR_VXRM, 1'b1, 32'hffff_fff2);
        csr_cycle(`VEC_CSR_VCSR, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VXRM, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VXSAT, 1'b1, 32'd1);
        csr_cycle(`VEC_CSR_VCSR, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VXSAT, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VCSR, 1'b1, 32'd6);
        csr_cycle(`VEC_CSR_VXRM, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VXSAT, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VSTART, 1'b1, 32'd5);
        csr_cycle(`VEC_CSR_VSTART, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VL, 1'b1, 32'd7);
        csr_cycle(`VEC_CSR_VTYPE, 1'b1, 32'd0);
        csr_cycle(`VEC_CSR_VLENB, 1'b1, 32'd0);
        csr_cycle(12'h123, 1'b0, 32'd0);
        csr_cycle(12'h7c0, 1'b1, 32'd3);
        csr_cycle(`VEC_CSR_VL, 1'b0, 32'd0);

        // First aadd of each mode issues with the vxrm write
        for (int m = 0; m < 4; m++) begin
            rng = xorshift(rng);
            next_cycle();
            drive_csr(`VEC_CSR_VXRM, 1'b1, 32'(m));
            issue_fixp(FIXP_AADD, rng[7:0], rng[15:8]);
            @(negedge clk);
            check_word("csr_rdata", csr_rdata, ref_read(`VEC_CSR_VXRM));
            for (int i = 0; i < N_RND; i++) begin
                rng = xorshift(rng);
                fixp_cycle(FIXP_AADD, rng[7:0], rng[15:8], `VEC_CSR_VCSR);
            end
        end

        csr_cycle(`VEC_CSR_VXSAT, 1'b1, 32'd0);
        fixp_cycle(FIXP_SADD, 8'd10, 8'd20, `VEC_CSR_VXSAT);
        csr_cycle(`VEC_CSR_VXSAT, 1'b0, 32'd0);
        fixp_cycle(FIXP_SADD, 8'd100, 8'd100, `VEC_CSR_VXSAT);
        csr_cycle(`VEC_CSR_VXSAT, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VCSR, 1'b0, 32'd0);
        fixp_cycle(FIXP_SADD, 8'd1, 8'd2, `VEC_CSR_VXSAT);
        csr_cycle(`VEC_CSR_VXSAT, 1'b0, 32'd0);
        csr_cycle(`VEC_CSR_VXSAT, 1'b1, 32'd0);
        fixp_cycle(FIXP_SADD, 8'h9c, 8'h9c, `VEC_CSR_VXSAT);
        // Clear lands in the same cycle as the set
        csr_cycle(`VEC_CSR_VXSAT, 1'b1, 32'd0);
        csr_cycle(`VEC_CSR_VXSAT, 1'b0, 32'd0);
        for (int i = 0; i < N_SAT; i++) begin
            rng = xorshift(rng);
            fixp_cycle(FIXP_SADD, rng[7:0], rng[15:8], `VEC_CSR_VCSR);
        end

        // Let the last result and flags pass the compare process
        next_cycle();
        next_cycle();
        next_cycle();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tests/vec_csr_assert.sv ====
// ======================================================================
// Vector CSR assertions
// Output sanity checks, bound to vector_csr
// ======================================================================
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_csr_assert (
    input logic            clk,
    input logic            rst,
    input vec_pkg::vtype_t vtype_out,
    input vec_pkg::vl_t    vl_out,
    input vec_pkg::vl_t    vstart_out,
    input vec_pkg::vxrm_e  vxrm_out,
    input logic            vxsat_out
);
    import vec_pkg::*;

    logic [31:0] vlmax;

    // Only meaningful while vill is clear
    assign vlmax = `VEC_VLEN >> (3 + 32'(vtype_out.sew));

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({vtype_out, vl_out, vstart_out, vxrm_out, vxsat_out}))
        else $error("vector CSR output is unknown");

    vl_in_range: assert property (@(posedge clk) disable iff (rst)
        vtype_out.vill || (32'(vl_out) <= vlmax))
        else $error("vl exceeds VLMAX for the current SEW");

    lmul_one: assert property (@(posedge clk) disable iff (rst)
        !vtype_out.vill |-> (vtype_out.vlmul == LMUL_1))
        else $error("vlmul is not 1 with vill clear");

endmodule

bind vector_csr vec_csr_assert u_assert (
    .clk(clk), .rst(rst), .vtype_out(vtype_out), .vl_out(vl_out),
    .vstart_out(vstart_out), .vxrm_out(vxrm_out), .vxsat_out(vxsat_out)
);

// ==== verilog/vec_csr_top.sv ====
// ======================================================================
// Vector CSR subsystem top
// vsetvl producer, CSR registers, CSR port and fixed-point consumer
// ======================================================================
`timescale 1ns/1ps

module vec_csr_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               vset_valid,
    input  vec_pkg::vset_req_t vset_req,
    input  logic               csr_valid,
    input  vec_pkg::csr_req_t  csr_req,
    input  logic               fixp_valid,
    input  vec_pkg::fixp_req_t fixp_req,
    output vec_pkg::vl_t       vl_out,
    output vec_pkg::vtype_t    vtype_out,
    output vec_pkg::csr_word_u csr_rdata,
    output logic               csr_err,
    output logic               fixp_rsp_valid,
    output vec_pkg::fixp_rsp_t fixp_rsp
);
    import vec_pkg::*;

    logic   vtype_wr;
    vtype_t vtype_new;
    logic   vl_wr;
    vl_t    vl_new;
    logic   vstart_wr;
    vl_t    vstart_data;
    vl_t    vstart_out;
    logic   vxrm_wr;
    vxrm_e  vxrm_data;
    vxrm_e  vxrm_out;
    logic   vxsat_wr;
    logic   vxsat_data;
    logic   vxsat_out;
    logic   vxsat_set;

    vsetvl_unit u_vsetvl (
        .clk, .rst, .vset_valid, .vset_req,
        .vtype_wr, .vtype_new, .vl_wr, .vl_new
    );

    vector_csr u_csr (
        .clk, .rst,
        .vtype_wr,  .vtype_in (vtype_new),
        .vl_wr,     .vl_in    (vl_new),
        .vstart_wr, .vstart_in(vstart_data),
        .vxrm_wr,   .vxrm_in  (vxrm_data),
        .vxsat_wr,  .vxsat_in (vxsat_data),
        .vxsat_set,
        .vtype_out, .vl_out, .vstart_out, .vxrm_out, .vxsat_out
    );

    csr_access u_access (
        .clk, .rst, .csr_valid, .csr_req,
        .vtype_val(vtype_out), .vl_val(vl_out), .vstart_val(vstart_out),
        .vxrm_val (vxrm_out),  .vxsat_val(vxsat_out),
        .vstart_wr, .vstart_data, .vxrm_wr, .vxrm_data, .vxsat_wr, .vxsat_data,
        .csr_rdata, .csr_err
    );

    fixp_alu u_fixp (
        .clk, .rst, .fixp_valid, .fixp_req,
        .vxrm(vxrm_out),
        .fixp_rsp_valid, .fixp_rsp, .vxsat_set
    );

endmodule

// ==== verilog/fixp_alu.sv ====
// ======================================================================
// Fixed-point ALU
// 8-bit averaging add rounded by vxrm and saturating add
// ======================================================================
`timescale 1ns/1ps

module fixp_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               fixp_valid,
    input  vec_pkg::fixp_req_t fixp_req,
    input  vec_pkg::vxrm_e     vxrm,
    output logic               fixp_rsp_valid,
    output vec_pkg::fixp_rsp_t fixp_rsp,
    output logic               vxsat_set
);
    import vec_pkg::*;

    logic [8:0] sum;
    logic       rnd;
    logic [7:0] avg;
    logic       ovf;
    fixp_rsp_t  rsp_next;

    // Sign-extended 9-bit sum never overflows
    assign sum = {fixp_req.a[7], fixp_req.a} + {fixp_req.b[7], fixp_req.b};

    always_comb begin
        case (vxrm)
            VXRM_RNU: rnd = sum[0];
            VXRM_RNE: rnd = sum[0] & sum[1];
            VXRM_RDN: rnd = 1'b0;
            default:  rnd = sum[0] & ~sum[1];   // rod: jam dropped bit into lsb
        endcase
    end

    assign avg = sum[8:1] + {7'b0, rnd};
    assign ovf = sum[8] ^ sum[7];

    always_comb begin
        rsp_next.sat = 1'b0;
        if (fixp_req.op == FIXP_AADD) begin
            rsp_next.result = avg;
        end else if (ovf) begin
            rsp_next.result = sum[8] ? 8'h80 : 8'h7f;
            rsp_next.sat    = 1'b1;
        end else begin
            rsp_next.result = sum[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fixp_rsp_valid <= 1'b0;
            vxsat_set      <= 1'b0;
        end else begin
            fixp_rsp_valid <= fixp_valid;
            vxsat_set      <= fixp_valid && rsp_next.sat;
        end
    end

    always_ff @(posedge clk) begin
        if (fixp_valid) begin
            fixp_rsp <= rsp_next;
        end
    end

endmodule

// ==== verilog/csr_access.sv ====
// ======================================================================
// CSR access port
// Decodes CSR reads and writes into register strobes and a read word
// ======================================================================
`timescale 1ns/1ps
`include "vec_defs.svh"

module csr_access (
    input  logic               clk,
    input  logic               rst,
    input  logic               csr_valid,
    input  vec_pkg::csr_req_t  csr_req,
    input  vec_pkg::vtype_t    vtype_val,
    input  vec_pkg::vl_t       vl_val,
    input  vec_pkg::vl_t       vstart_val,
    input  vec_pkg::vxrm_e     vxrm_val,
    input  logic               vxsat_val,
    output logic               vstart_wr,
    output vec_pkg::vl_t       vstart_data,
    output logic               vxrm_wr,
    output vec_pkg::vxrm_e     vxrm_data,
    output logic               vxsat_wr,
    output logic               vxsat_data,
    output vec_pkg::csr_word_u csr_rdata,
    output logic               csr_err
);
    import vec_pkg::*;

    logic is_write;
    logic is_vcsr;
    logic err;

    assign is_write = csr_valid && csr_req.write;
    assign is_vcsr  = (csr_req.addr == `VEC_CSR_VCSR);

    // vcsr packs both fields, the single registers use the low bits
    assign vstart_data = vl_t'(csr_req.wdata.raw);
    assign vxrm_data   = is_vcsr ? csr_req.wdata.vcsr.vxrm : vxrm_e'(csr_req.wdata.raw[1:0]);
    assign vxsat_data  = is_vcsr ? csr_req.wdata.vcsr.vxsat : csr_req.wdata.raw[0];

    always_comb begin
        vstart_wr     = 1'b0;
        vxrm_wr       = 1'b0;
        vxsat_wr      = 1'b0;
        err           = 1'b0;
        csr_rdata.raw = '0;
        case (csr_req.addr)
            `VEC_CSR_VSTART: begin
                vstart_wr     = is_write;
                csr_rdata.raw = 32'(vstart_val);
            end
            `VEC_CSR_VXSAT: begin
                vxsat_wr      = is_write;
                csr_rdata.raw = {31'b0, vxsat_val};
            end
            `VEC_CSR_VXRM: begin
                vxrm_wr       = is_write;
                csr_rdata.raw = {30'b0, vxrm_val};
            end
            `VEC_CSR_VCSR: begin
                vxrm_wr              = is_write;
                vxsat_wr             = is_write;
                csr_rdata.vcsr.vxrm  = vxrm_val;
                csr_rdata.vcsr.vxsat = vxsat_val;
            end
            `VEC_CSR_VL: begin
                csr_rdata.raw = 32'(vl_val);
                err           = is_write;
            end
            `VEC_CSR_VTYPE: begin
                csr_rdata.vtype = vtype_val;
                err             = is_write;
            end
            `VEC_CSR_VLENB: begin
                csr_rdata.raw = 32'(`VEC_VLEN / 8);
                err           = is_write;
            end
            default: err = csr_valid;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            csr_err <= 1'b0;
        end else begin
            csr_err <= err;
        end
    end

endmodule

// ==== verilog/vector_csr.sv ====
// ======================================================================
// Vector CSR registers
// vtype, vl, vstart, vxrm and vxsat with same-cycle write forwarding
// ======================================================================
`timescale 1ns/1ps
`include "vec_defs.svh"

module vector_csr (
    input  logic             clk,
    input  logic             rst,
    input  logic             vtype_wr,
    input  vec_pkg::vtype_t  vtype_in,
    input  logic             vl_wr,
    input  vec_pkg::vl_t     vl_in,
    input  logic             vstart_wr,
    input  vec_pkg::vl_t     vstart_in,
    input  logic             vxrm_wr,
    input  vec_pkg::vxrm_e   vxrm_in,
    input  logic             vxsat_wr,
    input  logic             vxsat_in,
    input  logic             vxsat_set,
    output vec_pkg::vtype_t  vtype_out,
    output vec_pkg::vl_t     vl_out,
    output vec_pkg::vl_t     vstart_out,
    output vec_pkg::vxrm_e   vxrm_out,
    output logic             vxsat_out
);
    import vec_pkg::*;

    vtype_t vtype_q;
    vl_t    vl_q;
    vl_t    vstart_q;
    vxrm_e  vxrm_q;
    logic   vxsat_q;
    logic   vxsat_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vtype_q  <= vtype_t'(`VEC_VTYPE_RST);
            vl_q     <= vl_t'(`VEC_VL_RST);
            vstart_q <= vl_t'(`VEC_VSTART_RST);
            vxrm_q   <= vxrm_e'(`VEC_VXRM_RST);
        end else begin
            if (vtype_wr) begin
                vtype_q <= vtype_in;
            end
            if (vl_wr) begin
                vl_q <= vl_in;
            end
            if (vstart_wr) begin
                vstart_q <= vstart_in;
            end
            if (vxrm_wr) begin
                vxrm_q <= vxrm_in;
            end
        end
    end

    // Sticky flag, a CSR write wins over the set
    assign vxsat_next = vxsat_wr ? vxsat_in : (vxsat_q | vxsat_set);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vxsat_q <= `VEC_VXSAT_RST;
        end else begin
            vxsat_q <= vxsat_next;
        end
    end

    // Forwarding
    assign vtype_out  = vtype_wr  ? vtype_in  : vtype_q;
    assign vl_out     = vl_wr     ? vl_in     : vl_q;
    assign vstart_out = vstart_wr ? vstart_in : vstart_q;
    assign vxrm_out   = vxrm_wr   ? vxrm_in   : vxrm_q;
    assign vxsat_out  = vxsat_next;

endmodule

// ==== verilog/vsetvl_unit.sv ====
// ======================================================================
// vsetvl unit
// Computes the new vtype and vl from AVL and the requested vtype
// ======================================================================
`timescale 1ns/1ps
`include "vec_defs.svh"

module vsetvl_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              vset_valid,
    input  vec_pkg::vset_req_t vset_req,
    output logic              vtype_wr,
    output vec_pkg::vtype_t   vtype_new,
    output logic              vl_wr,
    output vec_pkg::vl_t      vl_new
);
    import vec_pkg::*;

    logic [31:0] vlmax;
    logic        sew_ok;
    logic        illegal;

    // VLMAX = VLEN / SEW at LMUL 1
    always_comb begin
        sew_ok = 1'b1;
        case (vset_req.vtype.sew)
            SEW_8:   vlmax = `VEC_VLEN / 8;
            SEW_16:  vlmax = `VEC_VLEN / 16;
            SEW_32:  vlmax = `VEC_VLEN / 32;
            SEW_64:  vlmax = `VEC_VLEN / 64;
            default: begin
                vlmax  = '0;
                sew_ok = 1'b0;
            end
        endcase
    end

    assign illegal = !sew_ok || (vset_req.vtype.vlmul != LMUL_1);

    always_comb begin
        vtype_new      = vset_req.vtype;
        vtype_new.vill = 1'b0;
        vtype_new.rsvd = '0;
        if (illegal) begin
            vtype_new = vtype_t'(`VEC_VTYPE_RST);
        end
    end

    assign vl_new   = illegal ? '0 :
                      (vset_req.avl < vlmax) ? vl_t'(vset_req.avl) : vl_t'(vlmax);
    assign vtype_wr = vset_valid;
    assign vl_wr    = vset_valid;

endmodule

// ==== verilog/vec_pkg.sv ====
// ======================================================================
// Vector CSR package
// CSR field types, request structs and the CSR word union
// ======================================================================
`include "vec_defs.svh"

package vec_pkg;

    typedef enum logic [2:0] {
        SEW_8  = 3'b000,
        SEW_16 = 3'b001,
        SEW_32 = 3'b010,
        SEW_64 = 3'b011
    } sew_e;

    typedef enum logic [2:0] {
        LMUL_1  = 3'b000,
        LMUL_2  = 3'b001,
        LMUL_4  = 3'b010,
        LMUL_8  = 3'b011,
        LMUL_F8 = 3'b101,
        LMUL_F4 = 3'b110,
        LMUL_F2 = 3'b111
    } lmul_e;

    typedef struct packed {
        logic        vill;
        logic [22:0] rsvd;
        logic        ma;
        logic        ta;
        sew_e        sew;
        lmul_e       vlmul;
    } vtype_t;

    // Wide enough for VLMAX at SEW 8
    typedef logic [$clog2(`VEC_VLEN / 8):0] vl_t;

    typedef enum logic [1:0] {
        VXRM_RNU = 2'b00,
        VXRM_RNE = 2'b01,
        VXRM_RDN = 2'b10,
        VXRM_ROD = 2'b11
    } vxrm_e;

    typedef struct packed {
        logic [28:0] rsvd;
        vxrm_e       vxrm;
        logic        vxsat;
    } vcsr_t;

    typedef union packed {
        logic [31:0] raw;
        vcsr_t       vcsr;
        vtype_t      vtype;
    } csr_word_u;

    typedef struct packed {
        logic [31:0] avl;
        vtype_t      vtype;
    } vset_req_t;

    typedef struct packed {
        logic [11:0] addr;
        logic        write;
        csr_word_u   wdata;
    } csr_req_t;

    typedef enum logic {
        FIXP_AADD = 1'b0,
        FIXP_SADD = 1'b1
    } fixp_op_e;

    typedef struct packed {
        fixp_op_e    op;
        logic [7:0]  a;
        logic [7:0]  b;
    } fixp_req_t;

    typedef struct packed {
        logic [7:0]  result;
        logic        sat;
    } fixp_rsp_t;

endpackage

// ==== include/vec_defs.svh ====
// ======================================================================
// Vector CSR block build constants
// VLEN, CSR addresses and register reset values
// ======================================================================
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Vector register length in bits
`define VEC_VLEN        128

// CSR addresses
`define VEC_CSR_VSTART  12'h008
`define VEC_CSR_VXSAT   12'h009
`define VEC_CSR_VXRM    12'h00A
`define VEC_CSR_VCSR    12'h00F
`define VEC_CSR_VL      12'hC20
`define VEC_CSR_VTYPE   12'hC21
`define VEC_CSR_VLENB   12'hC22

// Reset values, vtype comes up with vill set
`define VEC_VTYPE_RST   32'h8000_0000
`define VEC_VL_RST      0
`define VEC_VSTART_RST  0
`define VEC_VXRM_RST    2'b00
`define VEC_VXSAT_RST   1'b0

`endif
